//--- design/lpcPkg.sv
package lpcPkg;

	//////////////////////////////
	// Sizes and layout
	//////////////////////////////

	// Predictor order, also the last coefficient index
	localparam int lpcOrder = 10;

	localparam int addrWidth = 12;
	localparam int dataWidth = 32;
	localparam int shortWidth = 16;
	localparam int memWords = 1 << addrWidth;

	// Peers sharing the bus
	localparam int numEngines = 2;
	localparam int engIdxWidth = (numEngines > 1) ? $clog2(numEngines) : 1;

	//////////////////////////////
	// Fixed-point constants
	//////////////////////////////

	// Added before the high half is taken
	localparam logic [dataWidth-1:0] roundConst = 32'h0000_8000;

	localparam logic [dataWidth-1:0] maxLong = 32'h7fff_ffff;
	localparam logic [dataWidth-1:0] minLong = 32'h8000_0000;
	localparam logic [shortWidth-1:0] maxShort = 16'h7fff;
	localparam logic [shortWidth-1:0] minShort = 16'h8000;

	//////////////////////////////
	// Bus payloads
	//////////////////////////////

	typedef struct packed {
		logic [addrWidth-1:0] readAddr;
		logic [addrWidth-1:0] writeAddr;
		logic [shortWidth-1:0] writeData;
		logic writeEn;
	} memReq_t;

	typedef struct packed {
		logic [shortWidth-1:0] multA;
		logic [shortWidth-1:0] multB;
		logic [dataWidth-1:0] addA;
		logic [dataWidth-1:0] addB;
		logic [shortWidth-1:0] shortA;
		logic [shortWidth-1:0] shortB;
	} mathReq_t;

	typedef struct packed {
		logic [dataWidth-1:0] multOut;
		logic [dataWidth-1:0] addOut;
		logic [shortWidth-1:0] shortOut;
	} mathRes_t;

	typedef struct packed {
		memReq_t mem;
		mathReq_t math;
	} busReq_t;

endpackage

//--- design/basicOps.sv
module basicOps
	import lpcPkg::*;
(
	input mathReq_t req,
	output mathRes_t res
);

	//////////////////////////////
	// Operators
	//////////////////////////////

	// Twice the signed product, the only overflow is -1 times -1
	function automatic logic [dataWidth-1:0] lMult(
		input logic [shortWidth-1:0] a,
		input logic [shortWidth-1:0] b
	);
		logic signed [dataWidth-1:0] prod;
		prod = $signed(a) * $signed(b);
		if (a == minShort && b == minShort)
			return maxLong;
		return {prod[dataWidth-2:0], 1'b0};
	endfunction

	// 32-bit add, clipped on overflow
	function automatic logic [dataWidth-1:0] lAdd(
		input logic [dataWidth-1:0] a,
		input logic [dataWidth-1:0] b
	);
		logic [dataWidth-1:0] sum;
		sum = a + b;
		if (a[dataWidth-1] == b[dataWidth-1] && sum[dataWidth-1] != a[dataWidth-1])
			return a[dataWidth-1] ? minLong : maxLong;
		return sum;
	endfunction

	// 16-bit add, clipped on overflow
	function automatic logic [shortWidth-1:0] addShort(
		input logic [shortWidth-1:0] a,
		input logic [shortWidth-1:0] b
	);
		logic [shortWidth-1:0] sum;
		sum = a + b;
		if (a[shortWidth-1] == b[shortWidth-1] && sum[shortWidth-1] != a[shortWidth-1])
			return a[shortWidth-1] ? minShort : maxShort;
		return sum;
	endfunction

	//////////////////////////////
	// Shared results
	//////////////////////////////

	always_comb
	begin
		res.multOut = lMult(req.multA, req.multB);
		res.addOut = lAdd(req.addA, req.addB);
		res.shortOut = addShort(req.shortA, req.shortB);
	end

endmodule

//--- design/busArbiter.sv
module busArbiter
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [numEngines-1:0] request,
	input busReq_t [numEngines-1:0] payloads,
	output logic [numEngines-1:0] grant,
	output busReq_t chosen
);

	// Current holder of the bus
	logic [engIdxWidth-1:0] owner;
	// Where the next search starts
	logic [engIdxWidth-1:0] pointer;

	logic [engIdxWidth-1:0] candidate;
	logic candidateFound;

	//////////////////////////////
	// Round-robin search
	//////////////////////////////

	always_comb
	begin : search
		int idx;
		candidate = owner;
		candidateFound = 1'b0;
		for (int k = 0; k < numEngines; k++)
		begin
			idx = (int'(pointer) + k) % numEngines;
			if (!candidateFound && request[idx])
			begin
				candidate = engIdxWidth'(idx);
				candidateFound = 1'b1;
			end
		end
	end

	// Handover only once the owner lets go
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			owner <= '0;
			pointer <= '0;
		end
		else if (!request[owner] && candidateFound)
		begin
			owner <= candidate;
			pointer <= engIdxWidth'((int'(candidate) + 1) % numEngines);
		end
	end

	//////////////////////////////
	// Grant and payload select
	//////////////////////////////

	always_comb
	begin
		grant = '0;
		chosen = '0;
		if (request[owner])
		begin
			grant[owner] = 1'b1;
			chosen = payloads[owner];
		end
	end

endmodule

//--- design/scratchMemory.sv
module scratchMemory
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input memReq_t bus,
	output logic [dataWidth-1:0] readData,
	input logic hostEn,
	input logic [addrWidth-1:0] hostAddr,
	input logic [dataWidth-1:0] hostWriteData,
	input logic hostWrite,
	output logic [dataWidth-1:0] hostReadData
);

	logic [dataWidth-1:0] mem [memWords];

	logic [addrWidth-1:0] readAddr;
	logic [addrWidth-1:0] writeAddr;
	logic [dataWidth-1:0] writeWord;
	logic writeEn;
	logic [dataWidth-1:0] readWord;

	// Host owns the port while the bus is idle
	always_comb
	begin
		if (hostEn)
		begin
			readAddr = hostAddr;
			writeAddr = hostAddr;
			writeWord = hostWriteData;
			writeEn = hostWrite;
		end
		else
		begin
			readAddr = bus.readAddr;
			writeAddr = bus.writeAddr;
			writeWord = {{(dataWidth - shortWidth){bus.writeData[shortWidth-1]}}, bus.writeData};
			writeEn = bus.writeEn;
		end
	end

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeWord;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			readWord <= '0;
		else
			readWord <= mem[readAddr];
	end

	assign readData = readWord;
	assign hostReadData = readWord;

endmodule

//--- design/weightAz.sv
module weightAz
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [addrWidth-1:0] aBase,
	input logic [addrWidth-1:0] apBase,
	input logic [addrWidth-1:0] gammaAddr,
	input logic grant,
	input logic [dataWidth-1:0] readData,
	input mathRes_t mathRes,
	output logic request,
	output busReq_t busOut,
	output logic done
);

	typedef enum logic [2:0] {
		sIdle,
		sWait,
		sCopy,
		sLoadFac,
		sLoopRead,
		sWriteAp,
		sUpdFac,
		sLast
	} state_t;

	state_t state;
	state_t nextState;

	logic [shortWidth-1:0] fac;
	logic [shortWidth-1:0] nextFac;
	logic [shortWidth-1:0] gamma;
	logic [shortWidth-1:0] nextGamma;
	logic [shortWidth-1:0] iter;
	logic [shortWidth-1:0] nextIter;

	logic [shortWidth-1:0] readShort;

	assign readShort = readData[shortWidth-1:0];

	// Coefficient i sits in the low nibble of the block base
	function automatic logic [addrWidth-1:0] coefAddr(
		input logic [addrWidth-1:0] base,
		input logic [shortWidth-1:0] idx
	);
		return {base[addrWidth-1:4], idx[3:0]};
	endfunction

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			iter <= '0;
		end
		else
		begin
			state <= nextState;
			iter <= nextIter;
		end
	end

	always_ff @(posedge clk)
	begin
		fac <= nextFac;
		gamma <= nextGamma;
	end

	assign request = (state != sIdle);

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_comb
	begin
		nextState = state;
		nextFac = fac;
		nextGamma = gamma;
		nextIter = iter;
		busOut = '0;
		done = 1'b0;

		case (state)
			sIdle:
			begin
				if (start)
					nextState = sWait;
			end

			// a[0] is fetched in the first granted cycle
			sWait:
			begin
				busOut.mem.readAddr = coefAddr(aBase, '0);
				if (grant)
					nextState = sCopy;
			end

			// ap[0] = a[0]
			sCopy:
			begin
				busOut.mem.writeAddr = coefAddr(apBase, '0);
				busOut.mem.writeData = readShort;
				busOut.mem.writeEn = 1'b1;
				busOut.mem.readAddr = gammaAddr;
				nextState = sLoadFac;
			end

			sLoadFac:
			begin
				nextFac = readShort;
				nextGamma = readShort;
				nextIter = shortWidth'(1);
				nextState = sLoopRead;
			end

			sLoopRead:
			begin
				busOut.mem.readAddr = coefAddr(aBase, iter);
				if (iter == shortWidth'(lpcOrder))
					nextState = sLast;
				else
					nextState = sWriteAp;
			end

			// ap[i] = round(a[i] * fac)
			sWriteAp, sLast:
			begin
				busOut.math.multA = readShort;
				busOut.math.multB = fac;
				busOut.math.addA = mathRes.multOut;
				busOut.math.addB = roundConst;
				busOut.mem.writeAddr = coefAddr(apBase, iter);
				busOut.mem.writeData = mathRes.addOut[dataWidth-1:shortWidth];
				busOut.mem.writeEn = 1'b1;
				if (state == sLast)
				begin
					done = 1'b1;
					nextState = sIdle;
				end
				else
					nextState = sUpdFac;
			end

			// fac = round(fac * gamma), step count through the shared adder
			sUpdFac:
			begin
				busOut.math.multA = fac;
				busOut.math.multB = gamma;
				busOut.math.addA = mathRes.multOut;
				busOut.math.addB = roundConst;
				busOut.math.shortA = iter;
				busOut.math.shortB = shortWidth'(1);
				nextFac = mathRes.addOut[dataWidth-1:shortWidth];
				nextIter = mathRes.shortOut;
				nextState = sLoopRead;
			end

			default:
				nextState = sIdle;
		endcase
	end

endmodule

//--- design/lpcWeightTop.sv
module lpcWeightTop
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [addrWidth-1:0] aBase,
	input logic [addrWidth-1:0] ap1Base,
	input logic [addrWidth-1:0] ap2Base,
	input logic [addrWidth-1:0] gamma1Addr,
	input logic [addrWidth-1:0] gamma2Addr,
	input logic [addrWidth-1:0] hostAddr,
	input logic [dataWidth-1:0] hostWriteData,
	input logic hostWrite,
	output logic [dataWidth-1:0] hostReadData,
	output logic done,
	output logic busy
);

	logic [numEngines-1:0] request;
	logic [numEngines-1:0] grant;
	logic [numEngines-1:0] engineDone;
	logic [numEngines-1:0] doneFlags;
	busReq_t [numEngines-1:0] payloads;
	busReq_t chosen;
	mathRes_t mathRes;
	logic [dataWidth-1:0] readData;
	logic hostEn;
	logic startEngines;

	// Start is dropped while a run is in progress
	assign startEngines = start & ~busy;
	assign hostEn = ~|grant;
	assign done = &doneFlags;

	//////////////////////////////
	// Run sequencing
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			doneFlags <= '0;
		end
		else if (done)
		begin
			busy <= 1'b0;
			doneFlags <= '0;
		end
		else
		begin
			if (startEngines)
				busy <= 1'b1;
			doneFlags <= doneFlags | engineDone;
		end
	end

	//////////////////////////////
	// Engines
	//////////////////////////////

	weightAz weightAz1_inst (
		.clk(clk),
		.reset(reset),
		.start(startEngines),
		.aBase(aBase),
		.apBase(ap1Base),
		.gammaAddr(gamma1Addr),
		.grant(grant[0]),
		.readData(readData),
		.mathRes(mathRes),
		.request(request[0]),
		.busOut(payloads[0]),
		.done(engineDone[0])
	);

	weightAz weightAz2_inst (
		.clk(clk),
		.reset(reset),
		.start(startEngines),
		.aBase(aBase),
		.apBase(ap2Base),
		.gammaAddr(gamma2Addr),
		.grant(grant[1]),
		.readData(readData),
		.mathRes(mathRes),
		.request(request[1]),
		.busOut(payloads[1]),
		.done(engineDone[1])
	);

	//////////////////////////////
	// Shared resources
	//////////////////////////////

	busArbiter busArbiter_inst (
		.clk(clk),
		.reset(reset),
		.request(request),
		.payloads(payloads),
		.grant(grant),
		.chosen(chosen)
	);

	basicOps basicOps_inst (
		.req(chosen.math),
		.res(mathRes)
	);

	scratchMemory scratchMemory_inst (
		.clk(clk),
		.reset(reset),
		.bus(chosen.mem),
		.readData(readData),
		.hostEn(hostEn),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWrite(hostWrite),
		.hostReadData(hostReadData)
	);

endmodule

//--- bench/busArbiter_props.sv
module busArbiterProps
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [numEngines-1:0] request,
	input logic [numEngines-1:0] grant,
	input logic start,
	input logic busy,
	input logic hostWrite
);

	grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("Grant is given to more than one engine");

	// Owner keeps the bus while it still requests
	for (genvar e = 0; e < numEngines; e++)
	begin : holdGrant
		ownerHolds: assert property (@(posedge clk) disable iff (reset)
			$past(grant[e]) && request[e] |-> grant[e])
			else $error("Engine %0d lost the grant while still requesting", e);
	end

	startWhileIdle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else $error("Start strobe arrived during a run");

	hostWhileIdle: assert property (@(posedge clk) disable iff (reset) hostWrite |-> grant == '0)
		else $error("Host write while an engine holds the bus");

endmodule

bind lpcWeightTop busArbiterProps busArbiterProps_inst (
	.clk(clk),
	.reset(reset),
	.request(request),
	.grant(grant),
	.start(start),
	.busy(busy),
	.hostWrite(hostWrite)
);

//--- bench/lpcWeightChecker.sv
module lpcWeightChecker
	import lpcPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input logic [addrWidth-1:0] aBase,
	input logic [addrWidth-1:0] ap1Base,
	input logic [addrWidth-1:0] ap2Base,
	input logic [addrWidth-1:0] gamma1Addr,
	input logic [addrWidth-1:0] gamma2Addr,
	input logic [addrWidth-1:0] hostAddr,
	input logic [dataWidth-1:0] hostWriteData,
	input logic hostWrite,
	input logic [dataWidth-1:0] hostReadData,
	input logic [8*12-1:0] testName,
	output int errors
);

	localparam longint wordMax = 64'sh0000_0000_7fff_ffff;
	localparam longint wordMin = -64'sh0000_0000_8000_0000;

	typedef logic [lpcOrder:0][shortWidth-1:0] coefSet_t;

	// Model of the scratch memory as the host should see it
	logic [dataWidth-1:0] shadow [memWords];
	logic shadowValid [memWords];

	logic running;
	logic [addrWidth-1:0] runA;
	logic [addrWidth-1:0] runAp1;
	logic [addrWidth-1:0] runAp2;
	logic [addrWidth-1:0] runG1;
	logic [addrWidth-1:0] runG2;
	logic readPending;
	logic [addrWidth-1:0] readAddr;
	logic [dataWidth-1:0] readExpect;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Doubled Q15 product rounded to the high half with clipping
	function automatic logic [shortWidth-1:0] roundedProduct(
		input logic [shortWidth-1:0] x,
		input logic [shortWidth-1:0] y
	);
		longint acc;
		acc = 2 * longint'($signed(x)) * longint'($signed(y));
		if (acc > wordMax)
			acc = wordMax;
		acc = acc + 32768;
		if (acc > wordMax)
			acc = wordMax;
		if (acc < wordMin)
			acc = wordMin;
		return shortWidth'(acc >>> 16);
	endfunction

	function automatic coefSet_t expectWeights(input coefSet_t a, input logic [15:0] gamma);
		coefSet_t ap;
		logic [shortWidth-1:0] fac;
		ap[0] = a[0];
		fac = gamma;
		for (int i = 1; i <= lpcOrder; i++)
		begin
			ap[i] = roundedProduct(a[i], fac);
			fac = roundedProduct(fac, gamma);
		end
		return ap;
	endfunction

	function automatic logic [addrWidth-1:0] blockAddr(input logic [addrWidth-1:0] base, input int i);
		return {base[addrWidth-1:4], 4'(i)};
	endfunction

	task automatic storeExpected(input logic [addrWidth-1:0] apBase, input logic [addrWidth-1:0] g);
		coefSet_t a;
		coefSet_t ap;
		for (int i = 0; i <= lpcOrder; i++)
			a[i] = shadow[blockAddr(runA, i)][shortWidth-1:0];
		ap = expectWeights(a, shadow[g][shortWidth-1:0]);
		for (int i = 0; i <= lpcOrder; i++)
		begin
			shadow[blockAddr(apBase, i)] = {{(dataWidth - shortWidth){ap[i][15]}}, ap[i]};
			shadowValid[blockAddr(apBase, i)] = 1'b1;
		end
	endtask

	//////////////////////////////
	// Comparison
	//////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			running = 1'b0;
			readPending = 1'b0;
			errors = 0;
			for (int i = 0; i < memWords; i++)
				shadowValid[i] = 1'b0;
		end
		else
		begin
			// Read issued one cycle ago
			if (readPending && hostReadData !== readExpect)
			begin
				$display("CHECK FAILED %s addr %h expected %h actual %h",
					testName, readAddr, readExpect, hostReadData);
				errors++;
			end
			if (busy !== running)
			begin
				$display("CHECK FAILED %s busy expected %b actual %b", testName, running, busy);
				errors++;
			end
			if (done && !running)
			begin
				$display("Done pulsed while no run was in progress in test %s", testName);
				errors++;
			end
			readPending = !running && shadowValid[hostAddr];
			readAddr = hostAddr;
			readExpect = shadow[hostAddr];
			if (hostWrite && !running)
			begin
				shadow[hostAddr] = hostWriteData;
				shadowValid[hostAddr] = 1'b1;
			end
			if (done && running)
			begin
				storeExpected(runAp1, runG1);
				storeExpected(runAp2, runG2);
				running = 1'b0;
			end
			if (start && !running)
			begin
				running = 1'b1;
				runA = aBase;
				runAp1 = ap1Base;
				runAp2 = ap2Base;
				runG1 = gamma1Addr;
				runG2 = gamma2Addr;
			end
		end
	end

endmodule

//--- bench/lpcWeightTb.sv
module lpcWeightTb
	import lpcPkg::*;
();

	localparam int doneTimeout = 200;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [addrWidth-1:0] aBase;
	logic [addrWidth-1:0] ap1Base;
	logic [addrWidth-1:0] ap2Base;
	logic [addrWidth-1:0] gamma1Addr;
	logic [addrWidth-1:0] gamma2Addr;
	logic [addrWidth-1:0] hostAddr;
	logic [dataWidth-1:0] hostWriteData;
	logic hostWrite;
	logic [dataWidth-1:0] hostReadData;
	logic done;
	logic busy;

	logic [31:0] seed;
	logic [8*12-1:0] testName;
	int checkErrors;
	int timeouts;

	always #20 clk = ~clk;

	lpcWeightTop lpcWeightTop_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.aBase(aBase),
		.ap1Base(ap1Base),
		.ap2Base(ap2Base),
		.gamma1Addr(gamma1Addr),
		.gamma2Addr(gamma2Addr),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWrite(hostWrite),
		.hostReadData(hostReadData),
		.done(done),
		.busy(busy)
	);

	lpcWeightChecker checker_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.aBase(aBase),
		.ap1Base(ap1Base),
		.ap2Base(ap2Base),
		.gamma1Addr(gamma1Addr),
		.gamma2Addr(gamma2Addr),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWrite(hostWrite),
		.hostReadData(hostReadData),
		.testName(testName),
		.errors(checkErrors)
	);

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [shortWidth-1:0] randomShort();
		seed = lcgNext(seed);
		return seed[31:16];
	endfunction

	// Positive Q15 value
	function automatic logic [shortWidth-1:0] randomGamma();
		logic [shortWidth-1:0] r;
		r = randomShort();
		return {1'b0, r[14:0]};
	endfunction

	function automatic logic [dataWidth-1:0] fillPattern(input logic [addrWidth-1:0] addr);
		return {4'ha, addr, 4'h5, addr};
	endfunction

	function automatic logic [dataWidth-1:0] signExtend(input logic [shortWidth-1:0] v);
		return {{(dataWidth - shortWidth){v[shortWidth-1]}}, v};
	endfunction

	// Called on a falling edge, returns on the next one
	task automatic hostWriteWord(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
		hostAddr = addr;
		hostWriteData = data;
		hostWrite = 1'b1;
		@(negedge clk);
		hostWrite = 1'b0;
	endtask

	task automatic writeCoef(input logic [addrWidth-1:0] base, input int i,
		input logic [shortWidth-1:0] value);
		hostWriteWord({base[addrWidth-1:4], 4'(i)}, signExtend(value));
	endtask

	task automatic loadRandomCoefs(input logic [addrWidth-1:0] base);
		for (int i = 0; i <= lpcOrder; i++)
			writeCoef(base, i, randomShort());
	endtask

	task automatic fillMemory();
		for (int i = 0; i < memWords; i++)
			hostWriteWord(addrWidth'(i), fillPattern(addrWidth'(i)));
	endtask

	// The checker compares each word as it comes back
	task automatic readAllMemory();
		for (int i = 0; i < memWords; i++)
		begin
			hostAddr = addrWidth'(i);
			@(negedge clk);
		end
	endtask

	task automatic runEngines(input logic [addrWidth-1:0] a, input logic [addrWidth-1:0] ap1,
		input logic [addrWidth-1:0] ap2, input logic [addrWidth-1:0] g1,
		input logic [addrWidth-1:0] g2);
		int cycles;
		aBase = a;
		ap1Base = ap1;
		ap2Base = ap2;
		gamma1Addr = g1;
		gamma2Addr = g2;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (!done && cycles < doneTimeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
		begin
			$display("Timeout: no done pulse within %0d cycles in test %s", doneTimeout, testName);
			timeouts++;
		end
		@(negedge clk);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		seed = 32'h409b;
		timeouts = 0;
		testName = "reset";
		reset = 1'b1;
		start = 1'b0;
		aBase = '0;
		ap1Base = '0;
		ap2Base = '0;
		gamma1Addr = '0;
		gamma2Addr = '0;
		hostAddr = '0;
		hostWriteData = '0;
		hostWrite = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		repeat (4) @(negedge clk);
		fillMemory();
		readAllMemory();

		testName = "random";
		loadRandomCoefs(12'h100);
		hostWriteWord(12'h400, signExtend(randomGamma()));
		hostWriteWord(12'h401, signExtend(randomGamma()));
		runEngines(12'h100, 12'h200, 12'h300, 12'h400, 12'h401);
		readAllMemory();

		// Most negative and most positive operands
		testName = "extreme";
		for (int i = 0; i <= lpcOrder; i++)
			writeCoef(12'h110, i, (i % 2 == 1) ? 16'h7fff : 16'h8000);
		hostWriteWord(12'h402, signExtend(16'h7fff));
		hostWriteWord(12'h403, signExtend(16'h8000));
		runEngines(12'h110, 12'h210, 12'h310, 12'h402, 12'h403);
		readAllMemory();

		testName = "backToBack";
		loadRandomCoefs(12'h120);
		for (int i = 0; i < 5; i++)
			hostWriteWord(addrWidth'(12'h404 + i), signExtend(randomGamma()));
		for (int run = 0; run < 3; run++)
			runEngines(12'h120, addrWidth'(12'h500 + run * 32), addrWidth'(12'h510 + run * 32),
				addrWidth'(12'h404 + run), 12'h408);
		readAllMemory();

		testName = "sameGamma";
		loadRandomCoefs(12'h130);
		hostWriteWord(12'h40a, signExtend(randomGamma()));
		runEngines(12'h130, 12'h230, 12'h330, 12'h40a, 12'h40a);
		readAllMemory();

		repeat (4) @(negedge clk);
		$display("Summary: %0d check errors, %0d timeouts", checkErrors, timeouts);
		if (checkErrors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- filelist.f
design/lpcPkg.sv
design/basicOps.sv
design/busArbiter.sv
design/scratchMemory.sv
design/weightAz.sv
design/lpcWeightTop.sv
bench/busArbiter_props.sv
bench/lpcWeightChecker.sv
bench/lpcWeightTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f filelist.f --top-module lpcWeightTb \
		-Mdir obj_dir -o lpcWeightTb

run: compile
	./obj_dir/lpcWeightTb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
